// ==== tetris_pkg.sv ====
package tetris_pkg;

  localparam int BOARD_W = 8;
  localparam int BOARD_H = 12;
  localparam int GRAVITY_TICKS = 32;
  localparam int PIECE_KINDS = 4; // widths 1 to 4.

  localparam int ROW_W = $clog2(BOARD_H);
  localparam int COL_W = $clog2(BOARD_W);
  localparam int KIND_W = $clog2(PIECE_KINDS);
  localparam int GRAV_W = $clog2(GRAVITY_TICKS);

  localparam logic [31:0] RNG_SEED = 32'h1d2c_3b4a;
  localparam logic [31:0] RNG_TAPS = 32'h8020_0003; // x^32+x^22+x^2+x+1.

  localparam logic [127:0] ROW_INIT = "????????????????";

  typedef enum logic [7:0] {
    IDLE  = 8'd0,
    FALL  = 8'd1,
    LOCK  = 8'd2,
    CLEAR = 8'd3,
    OVER  = 8'd4
  } state_type;

  typedef enum logic [7:0] {
    NONE  = 8'd0,
    LEFT  = 8'd1,
    RIGHT = 8'd2,
    DOWN  = 8'd3,
    DROP  = 8'd4,
    START = 8'd5
  } ctrl_type;

  typedef struct packed {
    state_type   state;
    logic [15:0] score;
    ctrl_type    last_ctrl;
  } game_status_t;

endpackage

// ==== prng.sv ====
`timescale 1ns/1ps

module prng (
  input  logic        clk_25MHz,
  input  logic        reset_n,
  output logic [31:0] rng
);

  import tetris_pkg::*;

  logic [31:0] shifted;

  // galois form, feedback from bit 0.
  assign shifted = {1'b0, rng[31:1]} ^ (rng[0] ? RNG_TAPS : 32'h0);

  always_ff @(posedge clk_25MHz) begin
    if (!reset_n) begin
      rng <= RNG_SEED; // never all zero.
    end else begin
      rng <= shifted;
    end
  end

endmodule

// ==== input_control.sv ====
`timescale 1ns/1ps

module input_control (
  input  logic                clk_25MHz,
  input  logic                reset_n,
  input  logic [3:0]          usr_btn,
  input  logic [3:0]          usr_sw,
  output tetris_pkg::ctrl_type ctrl
);

  import tetris_pkg::*;

  logic [3:0] btn_q;
  logic [3:0] sw_q;
  logic [3:0] btn_rise;
  logic [3:0] sw_rise;
  ctrl_type   next_ctrl;

  assign btn_rise = usr_btn & ~btn_q;
  assign sw_rise  = usr_sw & ~sw_q;

  // start first, then lowest button index.
  always_comb begin
    next_ctrl = NONE;
    if (|sw_rise) begin
      next_ctrl = START;
    end else if (btn_rise[0]) begin
      next_ctrl = LEFT;
    end else if (btn_rise[1]) begin
      next_ctrl = RIGHT;
    end else if (btn_rise[2]) begin
      next_ctrl = DOWN;
    end else if (btn_rise[3]) begin
      next_ctrl = DROP;
    end
  end

  always_ff @(posedge clk_25MHz) begin
    if (!reset_n) begin
      btn_q <= 4'h0;
      sw_q  <= 4'h0;
      ctrl  <= NONE;
    end else begin
      btn_q <= usr_btn;
      sw_q  <= usr_sw;
      ctrl  <= next_ctrl; // one cycle pulse.
    end
  end

endmodule

// ==== tetris_core.sv ====
`timescale 1ns/1ps

module tetris_core (
  input  logic                    clk_25MHz,
  input  logic                    reset_n,
  input  logic [31:0]             rng,
  input  tetris_pkg::ctrl_type     ctrl,
  output tetris_pkg::game_status_t status
);

  import tetris_pkg::*;

  logic [BOARD_W-1:0] board [BOARD_H];

  state_type   game_state;
  logic [15:0] score;
  ctrl_type    last_ctrl;
  logic [GRAV_W-1:0] grav_cnt;
  logic        dropping;
  logic [ROW_W-1:0] clear_row;

  logic [ROW_W-1:0]   p_row;
  logic [COL_W-1:0]   p_col;
  logic [BOARD_W-1:0] p_mask; // unshifted width mask.

  logic [BOARD_W-1:0] placed;
  logic [BOARD_W-1:0] spawn_mask;
  logic [BOARD_W-1:0] top_next;
  logic grav_tick;
  logic down_req;
  logic can_down;
  logic can_left;
  logic can_right;
  logic row_full;
  logic spawn_hit;

  function automatic logic [BOARD_W-1:0] piece_mask(input logic [KIND_W-1:0] kind);
    logic [BOARD_W-1:0] m;
    m = '0;
    for (int i = 0; i < PIECE_KINDS; i++) begin
      if (i <= int'(kind)) m[i] = 1'b1;
    end
    return m;
  endfunction

  assign placed     = p_mask << p_col;
  assign spawn_mask = piece_mask(rng[KIND_W-1:0]);
  assign grav_tick  = (grav_cnt == GRAV_W'(GRAVITY_TICKS - 1));
  assign down_req   = dropping || grav_tick || ctrl == DOWN || ctrl == DROP;
  assign can_down   = (p_row != ROW_W'(BOARD_H - 1)) && ((board[p_row + 1'b1] & placed) == '0);
  assign can_left   = !placed[0] && ((board[p_row] & (placed >> 1)) == '0);
  assign can_right  = !placed[BOARD_W-1] && ((board[p_row] & (placed << 1)) == '0);
  assign row_full   = &board[clear_row];
  assign top_next   = row_full ? '0 : board[0]; // top row empties on a clear.
  assign spawn_hit  = |(top_next & spawn_mask);

  assign status = '{state: game_state, score: score, last_ctrl: last_ctrl};

  always_ff @(posedge clk_25MHz) begin
    if (!reset_n) begin
      game_state <= IDLE;
      score      <= 16'h0;
      last_ctrl  <= NONE;
      grav_cnt   <= '0;
      dropping   <= 1'b0;
      clear_row  <= '0;
    end else begin
      if (ctrl != NONE) last_ctrl <= ctrl;
      case (game_state)
        IDLE, OVER: begin
          if (ctrl == START) begin
            game_state <= FALL;
            score      <= 16'h0;
            grav_cnt   <= '0;
            dropping   <= 1'b0;
          end
        end
        FALL: begin
          grav_cnt <= grav_tick ? '0 : grav_cnt + 1'b1;
          if (ctrl == DROP) dropping <= 1'b1;
          if (down_req && !can_down) begin
            game_state <= LOCK; // landed.
            dropping   <= 1'b0;
          end
        end
        LOCK: begin
          game_state <= CLEAR;
          clear_row  <= ROW_W'(BOARD_H - 1);
        end
        CLEAR: begin
          if (row_full) score <= score + 1'b1;
          if (clear_row == '0) begin
            game_state <= spawn_hit ? OVER : FALL;
            grav_cnt   <= '0;
          end else begin
            clear_row <= clear_row - 1'b1; // bottom up.
          end
        end
        default: game_state <= IDLE;
      endcase
    end
  end

  // board and falling piece.
  always_ff @(posedge clk_25MHz) begin
    case (game_state)
      IDLE, OVER: begin
        if (ctrl == START) begin
          for (int r = 0; r < BOARD_H; r++) board[r] <= '0;
          p_row  <= '0;
          p_col  <= '0;
          p_mask <= spawn_mask;
        end
      end
      FALL: begin
        if (down_req) begin
          if (can_down) p_row <= p_row + 1'b1;
        end else if (ctrl == LEFT && can_left) begin
          p_col <= p_col - 1'b1;
        end else if (ctrl == RIGHT && can_right) begin
          p_col <= p_col + 1'b1;
        end
      end
      LOCK: board[p_row] <= board[p_row] | placed;
      CLEAR: begin
        if (row_full) begin
          for (int r = 1; r < BOARD_H; r++) begin
            if (ROW_W'(r) <= clear_row) board[r] <= board[r-1];
          end
          board[0] <= '0;
        end
        if (clear_row == '0) begin
          p_row  <= '0;
          p_col  <= '0;
          p_mask <= spawn_mask;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== status_text.sv ====
`timescale 1ns/1ps

module status_text (
  input  logic                    clk_25MHz,
  input  logic                    reset_n,
  input  tetris_pkg::game_status_t status,
  output logic [127:0]            row_a,
  output logic [127:0]            row_b
);

  import tetris_pkg::*;

  logic [7:0]  st;
  logic [7:0]  lc;
  logic [15:0] sc;

  function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
    return {4'h0, nib} + ((nib < 4'd10) ? "0" : "A" - 8'd10);
  endfunction

  assign st = status.state;
  assign lc = status.last_ctrl;
  assign sc = status.score;

  always_ff @(posedge clk_25MHz) begin
    if (!reset_n) begin
      row_a <= ROW_INIT;
      row_b <= ROW_INIT;
    end else begin
      // char 0 is the top byte.
      row_a <= {hex_ascii(st[7:4]), hex_ascii(st[3:0]), {6{" "}},
                hex_ascii(sc[15:12]), hex_ascii(sc[11:8]),
                hex_ascii(sc[7:4]), hex_ascii(sc[3:0]), {4{" "}}};
      row_b <= {hex_ascii(lc[7:4]), hex_ascii(lc[3:0]), {14{" "}}};
    end
  end

endmodule

// ==== final_project.sv ====
`timescale 1ns/1ps

module final_project (
  input  logic                    clk_25MHz,
  input  logic                    reset_n,
  input  logic [3:0]              usr_btn,
  input  logic [3:0]              usr_sw,
  output logic [3:0]              usr_led,
  output tetris_pkg::game_status_t status,
  output logic [127:0]            row_a,
  output logic [127:0]            row_b
);

  import tetris_pkg::*;

  logic [31:0] rng;
  ctrl_type    ctrl;

  prng prng0 (
    .clk_25MHz (clk_25MHz),
    .reset_n   (reset_n),
    .rng       (rng)
  );

  input_control ctrl0 (
    .clk_25MHz (clk_25MHz),
    .reset_n   (reset_n),
    .usr_btn   (usr_btn),
    .usr_sw    (usr_sw),
    .ctrl      (ctrl)
  );

  tetris_core core0 (
    .clk_25MHz (clk_25MHz),
    .reset_n   (reset_n),
    .rng       (rng),
    .ctrl      (ctrl),
    .status    (status)
  );

  status_text text0 (
    .clk_25MHz (clk_25MHz),
    .reset_n   (reset_n),
    .status    (status),
    .row_a     (row_a),
    .row_b     (row_b)
  );

  assign usr_led = usr_btn ^ usr_sw; // led mirror.

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_25MHz
);

  initial clk_25MHz = 1'b0;

  always #20 clk_25MHz = ~clk_25MHz; // 40 ns period.

endmodule

// ==== final_project_properties.sv ====
`timescale 1ns/1ps

module final_project_properties (
  input logic                     clk_25MHz,
  input logic                     reset_n,
  input logic [3:0]               usr_btn,
  input logic [3:0]               usr_sw,
  input logic [3:0]               usr_led,
  input tetris_pkg::game_status_t status
);

  import tetris_pkg::*;

  state_type   state;
  ctrl_type    last_ctrl;
  logic [15:0] score;

  int unsigned led_errors = 0;
  int unsigned score_errors = 0;
  int unsigned over_errors = 0;

  assign state     = status.state;
  assign last_ctrl = status.last_ctrl;
  assign score     = status.score;

  led_mirror: assert property (@(posedge clk_25MHz) usr_led == (usr_btn ^ usr_sw))
    else begin
      led_errors++;
      $error("[ERROR] usr_led: got %h expected %h", usr_led, usr_btn ^ usr_sw);
    end

  // hold, +1 in clear, or back to zero on a restart.
  score_step: assert property (@(posedge clk_25MHz) disable iff (!reset_n)
    $past(reset_n) |-> (score == $past(score))
      || (score == $past(score) + 16'd1 && $past(state) == CLEAR)
      || (score == 16'd0 && state == FALL && ($past(state) == IDLE || $past(state) == OVER)))
    else begin
      score_errors++;
      $error("[ERROR] status.score: got %h after %h", score, $past(score));
    end

  over_hold: assert property (@(posedge clk_25MHz) disable iff (!reset_n)
    state == OVER |=> state == OVER || (state == FALL && last_ctrl == START))
    else begin
      over_errors++;
      $error("[ERROR] status.state: left OVER to %h with last_ctrl %h", state, last_ctrl);
    end

endmodule

bind final_project final_project_properties props (
  .clk_25MHz (clk_25MHz),
  .reset_n   (reset_n),
  .usr_btn   (usr_btn),
  .usr_sw    (usr_sw),
  .usr_led   (usr_led),
  .status    (status)
);

// ==== final_project_tb.sv ====
`timescale 1ns/1ps

module final_project_tb;

  import tetris_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int ROUNDS = 4;
  localparam int MOVES = 150;
  localparam int DROPS = 16;
  localparam int DROP_WAIT = 32;
  localparam int OVER_WAIT = 200;
  localparam int STIM_CYCLES = RESET_CYCLES + ROUNDS * (3 + MOVES * 9)
                               + 3 + DROPS * (DROP_WAIT + 2) + OVER_WAIT + 60;
  localparam int MARGIN_CYCLES = 1000;

  logic         clk_25MHz;
  logic         reset_n;
  logic [3:0]   usr_btn;
  logic [3:0]   usr_sw;
  logic [3:0]   usr_led;
  game_status_t status;
  logic [127:0] row_a;
  logic [127:0] row_b;

  logic         prev_rst_n = 1'b0;
  game_status_t prev_status;
  bit           reported = 1'b0;

  tb_clock clock0 (.clk_25MHz(clk_25MHz));

  final_project uut (
    .clk_25MHz (clk_25MHz),
    .reset_n   (reset_n),
    .usr_btn   (usr_btn),
    .usr_sw    (usr_sw),
    .usr_led   (usr_led),
    .status    (status),
    .row_a     (row_a),
    .row_b     (row_b)
  );

  task automatic stop_with_failure(input string what);
    reported = 1'b1;
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first failure");
  endtask

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    logic [127:0] digits;
    digits = "0123456789ABCDEF";
    return digits[8 * (15 - int'(nib)) +: 8];
  endfunction

  // chars 0 to 11 of row_a.
  function automatic logic [95:0] text_a(input game_status_t s);
    logic [7:0]  st;
    logic [95:0] t;
    st = s.state;
    t = {hex_char(st[7:4]), hex_char(st[3:0]), {6{8'h20}}, 32'h0};
    for (int i = 0; i < 4; i++) t[8*i +: 8] = hex_char(s.score[4*i +: 4]);
    return t;
  endfunction

  function automatic logic [127:0] text_b(input game_status_t s);
    logic [7:0] lc;
    lc = s.last_ctrl;
    return {hex_char(lc[7:4]), hex_char(lc[3:0]), {14{8'h20}}};
  endfunction

  // outputs are stable at the falling edge.
  always @(negedge clk_25MHz) begin
    assert (uut.props.led_errors + uut.props.score_errors + uut.props.over_errors == 0)
      else stop_with_failure("a bound assertion failed");
    if (!prev_rst_n) begin
      assert (status.state == IDLE && status.score == 16'h0 && status.last_ctrl == NONE)
        else stop_with_failure($sformatf("[ERROR] status: got %h expected %h",
                                         status, {IDLE, 16'h0, NONE}));
      assert (row_a == ROW_INIT && row_b == ROW_INIT)
        else stop_with_failure($sformatf("[ERROR] row_a/row_b: got %h / %h expected %h",
                                         row_a, row_b, ROW_INIT));
    end else begin
      assert (row_a[127:32] == text_a(prev_status))
        else stop_with_failure($sformatf("[ERROR] row_a: got %h expected %h",
                                         row_a[127:32], text_a(prev_status)));
      assert (row_b == text_b(prev_status))
        else stop_with_failure($sformatf("[ERROR] row_b: got %h expected %h",
                                         row_b, text_b(prev_status)));
    end
    prev_rst_n  = reset_n;
    prev_status = status;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_25MHz);
  endtask

  task automatic press_button(input int idx);
    @(posedge clk_25MHz);
    usr_btn <= 4'b0001 << idx;
    @(posedge clk_25MHz);
    usr_btn <= 4'b0000;
  endtask

  task automatic restart_game();
    int idx;
    idx = $urandom_range(3, 0);
    @(posedge clk_25MHz);
    usr_sw[idx] <= 1'b1;
    repeat (2) @(posedge clk_25MHz);
    usr_sw[idx] <= 1'b0;
  endtask

  task automatic random_move();
    int gap;
    int pick;
    gap = $urandom_range(7, 0);
    pick = $urandom_range(9, 0);
    idle_cycles(gap);
    if (pick == 9) begin
      @(posedge clk_25MHz);
      usr_btn <= 4'($urandom); // several edges at once.
      @(posedge clk_25MHz);
      usr_btn <= 4'b0000;
    end else begin
      press_button(pick % 4);
    end
  endtask

  initial begin
    #((STIM_CYCLES + MARGIN_CYCLES) * 40);
    stop_with_failure("watchdog expired before the stimulus finished");
  end

  initial begin
    void'($urandom(32'h53d6d7dd));
    reset_n = 1'b0;
    usr_btn = 4'b0000;
    usr_sw  = 4'b0000;
    idle_cycles(RESET_CYCLES);
    reset_n <= 1'b1;
    for (int r = 0; r < ROUNDS; r++) begin
      restart_game();
      for (int m = 0; m < MOVES; m++) random_move();
    end
    // column 0 stacks up until the spawn row is blocked.
    restart_game();
    for (int d = 0; d < DROPS; d++) begin
      press_button(3);
      idle_cycles(DROP_WAIT);
    end
    for (int w = 0; w < OVER_WAIT && status.state != OVER; w++) @(negedge clk_25MHz);
    if (status.state != OVER) stop_with_failure("the drop phase did not end in game over");
    idle_cycles(10);
    press_button(0);
    press_button(3);
    restart_game();
    idle_cycles(20);
    @(negedge clk_25MHz);
    if (uut.props.led_errors + uut.props.score_errors + uut.props.over_errors == 0) begin
      reported = 1'b1;
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("bound assertions failed during the run");
    end
  end

  final begin
    if (!reported) $display("TEST RESULT: FAIL");
  end

endmodule

// ==== final_project.f ====
tetris_pkg.sv
prng.sv
input_control.sv
tetris_core.sv
status_text.sv
final_project.sv
tb_clock.sv
final_project_properties.sv
final_project_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the final_project testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module final_project_tb \
  -f final_project.f --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim 2>&1)
sim_status=$?
printf '%s\n' "$out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
